// File: hdl/routing_pkg.sv
`default_nettype none

package routing_pkg;

	typedef logic [15:0] word_t;	// one memory word
	typedef logic [15:0] qvalue_t;	// route value in 11.5 fixed point

	// inputs of one route request, held by the user until done
	typedef struct packed {
		qvalue_t mybest;	// best value of this node
		word_t besthop;	// hop through the best neighbor
		qvalue_t bestvalue;	// value reported by the best neighbor
		word_t bestneighbor_id;	// id of the best neighbor
	} policy_request_t;

	// host written settings of the policy
	typedef struct packed {
		word_t my_node_id;
		word_t epsilon_step;	// epsilon decay per explore
	} policy_config_t;

	// byte addresses in node memory
	localparam word_t EPSILON_ADDR = 16'h0004;
	localparam word_t NEIGHBOR_LIST_ADDR = 16'h0668;	// 2 bytes per entry
	localparam word_t NEIGHBOR_COUNT_ADDR = 16'h068C;

	localparam word_t NO_HOP = 16'd65;	// stands for no next hop

	// thresholds around mybest
	localparam logic [15:0] LOW_FACTOR = 16'hFFBE;	// 0.999 in 0.16
	localparam logic [16:0] HIGH_FACTOR = 17'h10042;	// 1.001 in 1.16

endpackage

`default_nettype wire

// File: hdl/node_memory.sv
`timescale 1ns/10ps
`default_nettype none

module node_memory
	import routing_pkg::*;
#(
	parameter int mem_depth = 2048
) (
	input wire logic clock,
	// host port
	input wire logic [$clog2(mem_depth)-1:0] host_addr,
	input wire word_t host_wdata,
	input wire logic host_we,
	output word_t host_rdata,
	// policy port
	input wire logic [$clog2(mem_depth)-1:0] pol_addr,
	input wire word_t pol_wdata,
	input wire logic pol_we,
	output word_t pol_rdata
);

	localparam int aw = $clog2(mem_depth);

	logic [7:0] mem [mem_depth];	// byte array, no reset

	logic [aw-1:0] host_next;	// address of the low byte
	logic [aw-1:0] pol_next;

	assign host_next = host_addr + 1'b1;	// wraps at the top of memory
	assign pol_next = pol_addr + 1'b1;

	// words are big endian, high byte at the lower address
	assign host_rdata = {mem[host_addr], mem[host_next]};
	assign pol_rdata = {mem[pol_addr], mem[pol_next]};

	always_ff @(posedge clock) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata[15:8];
			mem[host_next] <= host_wdata[7:0];
		end
		// host and policy never write in the same cycle
		if (pol_we) begin
			mem[pol_addr] <= pol_wdata[15:8];
			mem[pol_next] <= pol_wdata[7:0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/lfsr_rng.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr_rng (
	input wire logic clock,
	input wire logic nrst,
	input wire logic rng_en,	// one step per enabled cycle
	output logic [3:0] draw
);

	// x^16 + x^14 + x^13 + x^11 + 1, maximal length
	localparam logic [15:0] taps = 16'hB400;
	localparam logic [15:0] seed = 16'hACE1;	// any nonzero value works

	logic [15:0] lfsr;
	logic [15:0] shifted;
	logic [15:0] feedback;

	// galois form shifting right
	// the bit that falls out toggles the tap positions
	assign shifted = {1'b0, lfsr[15:1]};
	assign feedback = lfsr[0] ? taps : 16'h0000;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			lfsr <= seed;	// all zero would lock up
		end else if (rng_en) begin
			lfsr <= shifted ^ feedback;
		end
	end

	// low nibble is the draw
	// new value is visible the cycle after rng_en
	assign draw = lfsr[3:0];

endmodule

`default_nettype wire

// File: hdl/neighbor_select.sv
`timescale 1ns/10ps
`default_nettype none

module neighbor_select
	import routing_pkg::*;
(
	input wire logic clock,
	input wire logic nrst,
	input wire logic sel_start,	// one cycle pulse
	input wire logic [3:0] draw,	// random draw to reduce
	input wire word_t count,	// better neighbor count
	output word_t index,	// draw mod count
	output logic sel_done	// one cycle pulse with index
);

	logic busy;
	word_t rem;	// running remainder
	word_t cnt;	// count latched at start

	word_t cur_rem;
	word_t cur_cnt;
	logic active;
	logic finish;

	// the start cycle already does the first compare
	assign cur_rem = sel_start ? {12'd0, draw} : rem;
	assign cur_cnt = sel_start ? count : cnt;
	assign active = sel_start || busy;
	// zero count ends at once with index 0
	assign finish = active && ((cur_cnt == '0) || (cur_rem < cur_cnt));

	always_ff @(posedge clock) begin
		if (!nrst) begin
			busy <= 1'b0;
			sel_done <= 1'b0;
		end else begin
			busy <= active && !finish;
			sel_done <= finish;	// high for one cycle only
		end
	end

	// remainder steps down by count each cycle
	always_ff @(posedge clock) begin
		if (active) begin
			cnt <= cur_cnt;
			rem <= cur_rem - cur_cnt;
		end
		if (finish) begin
			index <= (cur_cnt == '0) ? '0 : cur_rem;
		end
	end

endmodule

`default_nettype wire

// File: hdl/policy_config.sv
`timescale 1ns/10ps
`default_nettype none

module policy_config
	import routing_pkg::*;
(
	input wire logic clock,
	input wire logic nrst,
	input wire logic cfg_we,	// host write strobe
	input wire policy_config_t cfg_data,
	output policy_config_t cfg	// settings seen by the policy
);

	word_t step_in;

	// a zero step would leave epsilon stuck, so it becomes 1
	assign step_in = (cfg_data.epsilon_step == '0) ? 16'd1 : cfg_data.epsilon_step;

	// both fields are written together
	always_ff @(posedge clock) begin
		if (!nrst) begin
			cfg <= '0;
		end else if (cfg_we) begin
			cfg.my_node_id <= cfg_data.my_node_id;
			cfg.epsilon_step <= step_in;
		end
	end

	// the node id decides whether a close best neighbor is usable
	// the step is subtracted from epsilon after every explore
	// values hold until the next host write

endmodule

`default_nettype wire

// File: hdl/winner_policy.sv
`timescale 1ns/10ps
`default_nettype none

module winner_policy
	import routing_pkg::*;
#(
	parameter int mem_depth = 2048
) (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start,	// begins a request from idle
	input wire logic restart,	// back to idle from done
	input wire policy_request_t request,
	input wire policy_config_t cfg,
	// node memory policy port
	output logic [$clog2(mem_depth)-1:0] pol_addr,
	output word_t pol_wdata,
	output logic pol_we,
	input wire word_t pol_rdata,
	// random generator and neighbor select
	output logic rng_en,
	input wire logic [3:0] draw,
	output logic sel_start,
	input wire word_t index,
	input wire logic sel_done,
	output logic done,	// level, held until restart
	output word_t next_hop
);

	localparam int aw = $clog2(mem_depth);

	typedef enum logic [3:0] {
		S_DONE_WAIT,
		S_IDLE,
		S_DRAW,	// lfsr steps
		S_EPS,	// latch draw and epsilon
		S_DECIDE,	// explore or exploit
		S_MULT,	// exploit products
		S_CMP,
		S_RESULT,
		S_COUNT,	// explore, count on the bus
		S_SELECT,	// wait for the list index
		S_LIST,
		S_WSETUP,
		S_WRITE,	// epsilon written back
		S_FINISH
	} state_t;

	state_t state;

	logic [3:0] draw_q;	// explore draw
	word_t eps_q;	// epsilon from memory
	logic [32:0] left_q;	// bestvalue in 12.21
	logic [31:0] low_q;	// mybest * 0.999 in 11.21
	logic [32:0] high_q;	// mybest * 1.001 in 12.21
	logic win_low;
	logic win_close;
	logic other_id;	// best neighbor is not this node

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= S_DONE_WAIT;
			done <= 1'b0;
			next_hop <= NO_HOP;
			pol_we <= 1'b0;
			rng_en <= 1'b0;
			sel_start <= 1'b0;
		end else begin
			rng_en <= 1'b0;	// strobes default low
			sel_start <= 1'b0;
			pol_we <= 1'b0;
			case (state)
				S_DONE_WAIT: begin
					if (restart) begin
						state <= S_IDLE;
						done <= 1'b0;
						next_hop <= NO_HOP;
					end
				end
				S_IDLE: begin
					if (start) begin
						rng_en <= 1'b1;	// fresh draw for the epsilon test
						state <= S_DRAW;
					end
				end
				S_DRAW: state <= S_EPS;
				S_EPS: state <= S_DECIDE;
				S_DECIDE: begin
					if ({12'd0, draw_q} < eps_q) begin
						rng_en <= 1'b1;	// second draw feeds the select
						state <= S_COUNT;
					end else begin
						state <= S_MULT;
					end
				end
				S_MULT: state <= S_CMP;
				S_CMP: state <= S_RESULT;
				S_RESULT: begin
					// clear win, or close win through another node
					if (win_low || (win_close && other_id))
						next_hop <= request.besthop;
					else
						next_hop <= NO_HOP;
					state <= S_FINISH;
				end
				S_COUNT: begin
					sel_start <= 1'b1;	// select latches count from pol_rdata
					state <= S_SELECT;
				end
				S_SELECT: if (sel_done) state <= S_LIST;
				S_LIST: begin
					next_hop <= pol_rdata;	// picked neighbor id
					state <= S_WSETUP;
				end
				S_WSETUP: begin
					pol_we <= 1'b1;	// single write of epsilon
					state <= S_WRITE;
				end
				S_WRITE: state <= S_FINISH;
				S_FINISH: begin
					done <= 1'b1;
					state <= S_DONE_WAIT;
				end
				default: state <= S_DONE_WAIT;
			endcase
		end
	end

	// datapath registers follow the state
	always_ff @(posedge clock) begin
		case (state)
			S_DRAW: pol_addr <= aw'(EPSILON_ADDR);
			S_EPS: begin
				draw_q <= draw;
				eps_q <= pol_rdata;
			end
			S_DECIDE: pol_addr <= aw'(NEIGHBOR_COUNT_ADDR);
			S_MULT: begin
				left_q <= {1'b0, request.bestvalue, 16'h0000};
				low_q <= request.mybest * LOW_FACTOR;
				high_q <= request.mybest * HIGH_FACTOR;
			end
			S_CMP: begin
				win_low <= left_q < {1'b0, low_q};
				win_close <= left_q < high_q;
				other_id <= request.bestneighbor_id != cfg.my_node_id;
			end
			S_SELECT: begin
				if (sel_done)
					pol_addr <= aw'(NEIGHBOR_LIST_ADDR + {index[14:0], 1'b0});
			end
			S_LIST: begin
				// epsilon decays, floored at zero
				if (eps_q < cfg.epsilon_step)
					pol_wdata <= '0;
				else
					pol_wdata <= eps_q - cfg.epsilon_step;
			end
			S_WSETUP: pol_addr <= aw'(EPSILON_ADDR);
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/routing_node.sv
`timescale 1ns/10ps
`default_nettype none

module routing_node
	import routing_pkg::*;
#(
	parameter int mem_depth = 2048
) (
	input wire logic clock,
	input wire logic nrst,
	input wire logic [$clog2(mem_depth)-1:0] host_addr,
	input wire word_t host_wdata,
	input wire logic host_we,
	output word_t host_rdata,
	input wire logic cfg_we,
	input wire policy_config_t cfg_data,
	input wire policy_request_t request,	// held during a request
	input wire logic start,
	input wire logic restart,
	output logic done,
	output word_t next_hop
);

	localparam int aw = $clog2(mem_depth);

	logic [aw-1:0] pol_addr;
	word_t pol_wdata;
	word_t pol_rdata;	// also the count seen by the select
	logic pol_we;
	logic rng_en;
	logic [3:0] draw;	// shared by policy and select
	logic sel_start;
	word_t index;
	logic sel_done;
	policy_config_t cfg;

	node_memory #(.mem_depth(mem_depth)) node_memory_inst (
		.clock(clock), .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we),
		.host_rdata(host_rdata), .pol_addr(pol_addr), .pol_wdata(pol_wdata),
		.pol_we(pol_we), .pol_rdata(pol_rdata));

	lfsr_rng lfsr_rng_inst (.clock(clock), .nrst(nrst), .rng_en(rng_en), .draw(draw));

	neighbor_select neighbor_select_inst (
		.clock(clock), .nrst(nrst), .sel_start(sel_start), .draw(draw),
		.count(pol_rdata), .index(index), .sel_done(sel_done));

	policy_config policy_config_inst (
		.clock(clock), .nrst(nrst), .cfg_we(cfg_we), .cfg_data(cfg_data), .cfg(cfg));

	winner_policy #(.mem_depth(mem_depth)) winner_policy_inst (
		.clock(clock), .nrst(nrst), .start(start), .restart(restart), .request(request),
		.cfg(cfg), .pol_addr(pol_addr), .pol_wdata(pol_wdata), .pol_we(pol_we),
		.pol_rdata(pol_rdata), .rng_en(rng_en), .draw(draw), .sel_start(sel_start),
		.index(index), .sel_done(sel_done), .done(done), .next_hop(next_hop));

endmodule

`default_nettype wire

// File: dv/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 16
) (
	output logic clock,
	output logic nrst	// active low, released on a rising edge
);

	initial begin
		clock = 1'b0;
		forever #(period_ns / 2) clock = ~clock;
	end

	initial begin
		nrst = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		nrst <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/routing_node_assert.sv
`timescale 1ns/10ps
`default_nettype none

module routing_node_assert (
	input wire logic clock,
	input wire logic nrst,
	input wire logic pol_we,
	input wire logic rng_en,
	input wire logic sel_start,
	input wire logic done,
	input wire logic [15:0] next_hop
);

	int failures;	// failed assertion count, read by the testbench

	initial failures = 0;

	// memory stays untouched once the result is out
	assert property (@(posedge clock) disable iff (!nrst) done |-> !pol_we)
		else begin
			failures++;
			$error("policy wrote memory while done was high");
		end

	assert property (@(posedge clock) disable iff (!nrst) rng_en |=> !rng_en)
		else begin
			failures++;
			$error("rng_en stayed high for more than one cycle");
		end

	assert property (@(posedge clock) disable iff (!nrst) sel_start |=> !sel_start)
		else begin
			failures++;
			$error("sel_start stayed high for more than one cycle");
		end

	// restart drops done on the same edge that clears next_hop
	assert property (@(posedge clock) disable iff (!nrst) done |=> (!done || $stable(next_hop)))
		else begin
			failures++;
			$error("next_hop changed while done was high");
		end

endmodule

bind winner_policy routing_node_assert routing_node_assert_inst (
	.clock(clock), .nrst(nrst), .pol_we(pol_we), .rng_en(rng_en),
	.sel_start(sel_start), .done(done), .next_hop(next_hop));

`default_nettype wire

// File: dv/routing_node_tb.sv
`timescale 1ns/10ps
`default_nettype none

module routing_node_tb
	import routing_pkg::*;
();

	localparam int aw = 11;	// 2048 byte memory
	localparam int fields = 11;	// words per case line
	localparam int max_cases = 32;
	localparam int list_len = 18;	// entries between list and count addresses

	logic clock;
	logic nrst;
	logic [aw-1:0] host_addr;
	word_t host_wdata;
	logic host_we;
	word_t host_rdata;
	logic cfg_we;
	policy_config_t cfg_data;
	policy_request_t request;
	logic start;
	logic restart;
	logic done;
	word_t next_hop;

	word_t cases [fields * max_cases];
	word_t neighbors [list_len];	// ids written into the better-neighbor list
	int n_cases;
	int value_errors;
	int other_errors;
	int assert_errors;

	clock_gen #(.period_ns(40), .reset_cycles(16)) clock_gen_inst (.clock(clock), .nrst(nrst));

	routing_node #(.mem_depth(2048)) routing_node_inst (
		.clock(clock), .nrst(nrst), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_we(host_we), .host_rdata(host_rdata), .cfg_we(cfg_we), .cfg_data(cfg_data),
		.request(request), .start(start), .restart(restart), .done(done),
		.next_hop(next_hop));

	task automatic compare(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// exploit hop from the case line or explore hop from the neighbor list
	task automatic check_hop(input string name, input word_t mode, input word_t expected,
		input word_t count);
		logic found;
		if (mode == 16'd0) begin
			compare(name, expected, next_hop);
		end else begin
			found = 1'b0;
			for (int k = 0; k < count && k < list_len; k++)
				if (neighbors[k] == next_hop) found = 1'b1;
			if (!found) begin
				other_errors++;
				$display("%s explore picked %h which is not among the first %0d neighbors",
					name, next_hop, count);
			end
		end
	endtask

	task automatic host_write(input word_t addr, input word_t data);
		@(posedge clock);
		host_addr <= aw'(addr);
		host_wdata <= data;
		host_we <= 1'b1;
		@(posedge clock);
		host_we <= 1'b0;
	endtask

	task automatic run_case(input int i);
		word_t f [fields];
		string tag;
		int cycles;
		for (int k = 0; k < fields; k++) f[k] = cases[i * fields + k];
		tag = $sformatf("case %0d", i);
		host_write(EPSILON_ADDR, f[6]);	// epsilon 16 forces explore, 0 forces exploit
		host_write(NEIGHBOR_COUNT_ADDR, f[8]);
		@(posedge clock);
		cfg_we <= 1'b1;
		cfg_data <= '{my_node_id: f[5], epsilon_step: f[7]};
		request <= '{mybest: f[1], besthop: f[2], bestvalue: f[3], bestneighbor_id: f[4]};
		restart <= 1'b1;	// leaves done-wait
		@(posedge clock);
		cfg_we <= 1'b0;
		restart <= 1'b0;
		@(negedge clock);
		compare({tag, " done after restart"}, 16'd0, {15'd0, done});
		compare({tag, " hop after restart"}, NO_HOP, next_hop);
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		cycles = 0;
		while (!done && cycles < 40) begin	// longest explore is 9 + 16 cycles
			@(negedge clock);
			cycles++;
		end
		if (!done) begin
			other_errors++;
			$display("%s done did not rise within 40 cycles of start", tag);
		end else begin
			check_hop({tag, " next_hop"}, f[0], f[9], f[8]);
			@(posedge clock);
			host_addr <= aw'(EPSILON_ADDR);	// combinational read
			@(negedge clock);
			compare({tag, " epsilon"}, f[10], host_rdata);
			repeat (3) @(negedge clock);	// result must hold until restart
			compare({tag, " done held"}, 16'd1, {15'd0, done});
			check_hop({tag, " hop held"}, f[0], f[9], f[8]);
		end
	endtask

	initial begin
		host_addr = '0;
		host_wdata = '0;
		host_we = 1'b0;
		cfg_we = 1'b0;
		cfg_data = '0;
		request = '0;
		start = 1'b0;
		restart = 1'b0;
		value_errors = 0;
		other_errors = 0;
		assert_errors = 0;
		n_cases = 0;
		void'($urandom(32'h97ce));
		$readmemh("dv/routing_node_cases.txt", cases);
		while (n_cases < max_cases && cases[n_cases * fields] != 16'hFFFF) n_cases++;
		if (n_cases == 0) begin
			other_errors++;
			$display("no cases were read from the case file");
		end
		wait (nrst);
		// high byte keeps the ids distinct and away from NO_HOP
		for (int k = 0; k < list_len; k++) begin
			neighbors[k] = {8'(k + 1), 8'($urandom())};
			host_write(NEIGHBOR_LIST_ADDR + word_t'(2 * k), neighbors[k]);
		end
		for (int i = 0; i < n_cases; i++) run_case(i);
		assert_errors = routing_node_inst.winner_policy_inst.routing_node_assert_inst.failures;
		$display("%0d cases run, %0d value errors, %0d other errors, %0d assertion failures",
			n_cases, value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		int limit;
		wait (n_cases > 0);
		limit = n_cases * 60 + 16 + 2 * list_len + 8;	// reset and list fill on top
		repeat (limit) @(posedge clock);
		$display("watchdog expired after %0d cycles before the run finished", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/routing_node_cases.txt
// columns mode mybest besthop bestvalue best_id node_id eps step count hop eps_after
// mode 0 is exploit and 1 is explore where the hop is checked against the neighbor list
0 0640 0017 0500 0009 0003 0000 0001 0000 0017 0000
0 0640 0018 063e 0009 0003 0000 0001 0000 0018 0000
0 0640 0022 063f 0009 0003 0000 0001 0000 0022 0000
0 0640 0023 0641 0009 0003 0000 0001 0000 0023 0000
0 0640 0024 0640 0003 0003 0000 0001 0000 0041 0000
0 0640 0025 0641 0007 0007 0000 0001 0000 0041 0000
0 0640 0026 0642 0009 0003 0000 0001 0000 0041 0000
0 0640 0027 0800 0009 0003 0000 0001 0000 0041 0000
0 0020 0028 0010 0009 0003 0000 0001 0000 0028 0000
1 0640 0017 0500 0009 0003 0010 0003 0005 0000 000d
1 0640 0017 0500 0009 0003 0010 0020 0012 0000 0000
1 0640 0017 0500 0009 0003 0010 0000 0001 0000 000f
1 0640 0017 0500 0009 0003 0010 0010 000c 0000 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: list.f
hdl/routing_pkg.sv
hdl/node_memory.sv
hdl/lfsr_rng.sv
hdl/neighbor_select.sv
hdl/policy_config.sv
hdl/winner_policy.sv
hdl/routing_node.sv
dv/clock_gen.sv
dv/routing_node_assert.sv
dv/routing_node_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module routing_node_tb -f list.f -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -q -x '\*\* PASS \*\*' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
